// ==== test_signal_pkg.sv ====
// shared constants and types; raster sizes fit 10 bits, i2s divider and slot counts are powers of two
package test_signal_pkg;

    ////////////////////////////////////////////////////////////
    // raster timing
    ////////////////////////////////////////////////////////////

    // one mclk per pixel, 400 x 512 = 204800 clocks per frame
    localparam int unsigned pos_w      = 10;
    localparam logic [9:0]  h_total    = 10'd400;
    localparam logic [9:0]  h_active   = 10'd320;
    localparam logic [9:0]  h_bporch   = 10'd10;
    localparam logic [9:0]  v_total    = 10'd512;
    localparam logic [9:0]  v_active   = 10'd240;
    localparam logic [9:0]  v_bporch   = 10'd10;
    // hsync a few clocks after vsync, never on the same cycle
    localparam logic [9:0]  hs_column  = 10'd3;
    // orange fill
    localparam logic [23:0] active_rgb = 24'hFF5F00;

    ////////////////////////////////////////////////////////////
    // i2s framing
    ////////////////////////////////////////////////////////////

    localparam int unsigned mclk_per_bit     = 4;
    localparam int unsigned bits_per_channel = 32;
    localparam int unsigned sample_bits      = 16;

    // derived counter widths and terminal counts
    localparam int unsigned div_w  = $clog2(mclk_per_bit);
    localparam int unsigned slot_w = $clog2(2 * bits_per_channel);
    localparam int unsigned seg_w  = $clog2(sample_bits);
    localparam logic [div_w-1:0]  div_last  = div_w'(mclk_per_bit - 1);
    localparam logic [slot_w-1:0] slot_last = slot_w'(2 * bits_per_channel - 1);
    localparam logic [seg_w-1:0]  seg_last  = seg_w'(sample_bits - 1);

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [pos_w-1:0] x;
        logic [pos_w-1:0] y;
    } raster_pos_t;

    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        hs;
        logic        vs;
    } video_out_t;

    typedef struct packed {
        logic [sample_bits-1:0] left;
        logic [sample_bits-1:0] right;
    } audio_sample_t;

    // one phase per 16-slot quarter of the frame
    typedef enum logic [1:0] {
        left_data  = 2'd0,
        left_pad   = 2'd1,
        right_data = 2'd2,
        right_pad  = 2'd3
    } i2s_state_t;

    typedef struct packed {
        logic shift_en;   // end of a bit slot
        logic frame_load; // end of slot 63, next slot is bit 0
        logic right_sel;
        logic pad;
        logic sclk;
        logic lrck;
    } i2s_ctrl_t;

    typedef struct packed {
        logic sclk;
        logic lrck;
        logic dac;
    } i2s_out_t;

endpackage

// ==== raster_counter.sv ====
// free-running raster position, one pixel per mclk, no blanking or enable input
`timescale 1ns/10ps

module raster_counter (
    input  logic                         audgen_mclk,
    input  logic                         reset_n,
    output test_signal_pkg::raster_pos_t pos
);

    logic [test_signal_pkg::pos_w-1:0] x_count;
    logic [test_signal_pkg::pos_w-1:0] y_count;
    logic                              x_wrap;
    logic                              y_wrap;

    // terminal counts
    assign x_wrap = (x_count == test_signal_pkg::h_total - 10'd1);
    assign y_wrap = (y_count == test_signal_pkg::v_total - 10'd1);

    ////////////////////////////////////////////////////////////
    // horizontal
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
        end else if (x_wrap) begin
            x_count <= '0;
        end else begin
            x_count <= x_count + 10'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // vertical
    ////////////////////////////////////////////////////////////

    // steps once per line, on the last column
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            y_count <= '0;
        end else if (x_wrap) begin
            if (y_wrap) begin
                y_count <= '0;
            end else begin
                y_count <= y_count + 10'd1;
            end
        end
    end

    // position out
    assign pos.x = x_count;
    assign pos.y = y_count;

endmodule

// ==== video_pattern.sv ====
// registered sync and colour, so every output trails the raster position by one mclk
`timescale 1ns/10ps

module video_pattern (
    input  logic                         audgen_mclk,
    input  logic                         reset_n,
    input  test_signal_pkg::raster_pos_t pos,
    output test_signal_pkg::video_out_t  video
);

    logic in_h;
    logic in_v;
    logic in_window;
    logic frame_start;
    logic line_sync;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    // active columns 10..329
    assign in_h = (pos.x >= test_signal_pkg::h_bporch) &&
                  (pos.x <  test_signal_pkg::h_bporch + test_signal_pkg::h_active);

    // active lines 10..249
    assign in_v = (pos.y >= test_signal_pkg::v_bporch) &&
                  (pos.y <  test_signal_pkg::v_bporch + test_signal_pkg::v_active);

    assign in_window = in_h && in_v;

    // new frame at the origin
    assign frame_start = (pos.x == 10'd0) && (pos.y == 10'd0);

    // new line, a little after vs so the two never coincide
    assign line_sync = (pos.x == test_signal_pkg::hs_column);

    ////////////////////////////////////////////////////////////
    // output stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video.rgb <= '0;
            video.de  <= 1'b0;
            video.hs  <= 1'b0;
            video.vs  <= 1'b0;
        end else begin
            video.vs <= frame_start;
            video.hs <= line_sync;
            video.de <= in_window;
            // black outside the window
            if (in_window) begin
                video.rgb <= test_signal_pkg::active_rgb;
            end else begin
                video.rgb <= 24'h000000;
            end
        end
    end

endmodule

// ==== i2s_sequencer.sv ====
// i2s frame timing only with sclk at mclk / 4 and 64 slots per frame, 16 per channel carrying data
`timescale 1ns/10ps

module i2s_sequencer (
    input  logic                       audgen_mclk,
    input  logic                       reset_n,
    output test_signal_pkg::i2s_ctrl_t ctrl
);

    logic [test_signal_pkg::div_w-1:0]  div;
    logic [test_signal_pkg::slot_w-1:0] slot;
    test_signal_pkg::i2s_state_t        state;
    test_signal_pkg::i2s_state_t        state_next;
    logic                               slot_end;
    logic                               seg_end;

    // last mclk of a bit slot
    assign slot_end = (div == test_signal_pkg::div_last);
    // last slot of a 16-slot quarter
    assign seg_end = slot_end &&
                     (slot[test_signal_pkg::seg_w-1:0] == test_signal_pkg::seg_last);

    ////////////////////////////////////////////////////////////
    // bit clock divider and slot counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div <= '0;
        end else if (slot_end) begin
            div <= '0;
        end else begin
            div <= div + 2'd1;
        end
    end

    // slot advances together with the falling sclk
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot <= '0;
        end else if (slot_end) begin
            if (slot == test_signal_pkg::slot_last) begin
                slot <= '0;
            end else begin
                slot <= slot + 6'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // channel phase FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            test_signal_pkg::left_data:  state_next = test_signal_pkg::left_pad;
            test_signal_pkg::left_pad:   state_next = test_signal_pkg::right_data;
            test_signal_pkg::right_data: state_next = test_signal_pkg::right_pad;
            default:                     state_next = test_signal_pkg::left_data;
        endcase
    end

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            state <= test_signal_pkg::left_data;
        end else if (seg_end) begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // strobes and levels
    ////////////////////////////////////////////////////////////

    always_comb begin
        ctrl.shift_en   = slot_end;
        // the shift that closes slot 63 also opens the next frame
        ctrl.frame_load = slot_end && (slot == test_signal_pkg::slot_last);
        ctrl.right_sel  = (state == test_signal_pkg::right_data) ||
                          (state == test_signal_pkg::right_pad);
        ctrl.pad        = (state == test_signal_pkg::left_pad) ||
                          (state == test_signal_pkg::right_pad);
        // high for divider 2 and 3
        ctrl.sclk       = div[test_signal_pkg::div_w-1];
        // low for slots 0..31 and high for 32..63
        ctrl.lrck       = slot[test_signal_pkg::slot_w-1];
    end

endmodule

// ==== i2s_serializer.sv ====
// sample is read only at frame_load, the frame right after reset carries zeros
`timescale 1ns/10ps

module i2s_serializer (
    input  logic                           audgen_mclk,
    input  logic                           reset_n,
    input  test_signal_pkg::i2s_ctrl_t     ctrl,
    input  test_signal_pkg::audio_sample_t sample,
    output logic                           dac,
    output logic                           sample_taken
);

    logic [test_signal_pkg::sample_bits-1:0] right_word;
    logic [test_signal_pkg::sample_bits-1:0] shreg;

    ////////////////////////////////////////////////////////////
    // sample latch
    ////////////////////////////////////////////////////////////

    // left goes straight into the shifter, right waits here
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            right_word   <= '0;
            sample_taken <= 1'b0;
        end else begin
            sample_taken <= ctrl.frame_load;
            if (ctrl.frame_load) begin
                right_word <= sample.right;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // shift register, msb first
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            shreg <= '0;
        end else if (ctrl.frame_load) begin
            shreg <= sample.left;
        end else if (ctrl.pad && !ctrl.right_sel) begin
            // parked on the right word through the left pad slots
            // so it is in place when right_sel rises
            shreg <= right_word;
        end else if (ctrl.shift_en) begin
            shreg <= {shreg[test_signal_pkg::sample_bits-2:0], 1'b0};
        end
    end

    // zero bits during pad slots
    assign dac = shreg[test_signal_pkg::sample_bits-1] && !ctrl.pad;

endmodule

// ==== test_signal_top.sv ====
// raster pattern and i2s frame on one clock, mclk doubles as pixel clock at 12.288 MHz
`timescale 1ns/10ps

module test_signal_top (
    input  logic                           audgen_mclk,
    input  logic                           reset_n,
    input  test_signal_pkg::audio_sample_t sample,
    output test_signal_pkg::video_out_t    video,
    output test_signal_pkg::i2s_out_t      i2s,
    output logic                           sample_taken
);

    test_signal_pkg::raster_pos_t pos;
    test_signal_pkg::i2s_ctrl_t   ctrl;
    logic                         dac;

    ////////////////////////////////////////////////////////////
    // video
    ////////////////////////////////////////////////////////////

    raster_counter raster_counter_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (pos)
    );

    video_pattern video_pattern_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (pos),
        .video       (video)
    );

    ////////////////////////////////////////////////////////////
    // audio
    ////////////////////////////////////////////////////////////

    i2s_sequencer i2s_sequencer_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .ctrl        (ctrl)
    );

    i2s_serializer i2s_serializer_i (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .ctrl         (ctrl),
        .sample       (sample),
        .dac          (dac),
        .sample_taken (sample_taken)
    );

    // clock levels come from the sequencer, data from the shifter
    assign i2s.sclk = ctrl.sclk;
    assign i2s.lrck = ctrl.lrck;
    assign i2s.dac  = dac;

endmodule

// ==== tb_clock_gen.sv ====
// free-running 100 ns clock; reset low for 16 rising edges, then released on a falling edge
`timescale 1ns/10ps

module tb_clock_gen (
    output logic audgen_mclk,
    output logic reset_n
);

    // 50 ns per half period
    initial begin
        audgen_mclk = 1'b0;
        forever #50 audgen_mclk = ~audgen_mclk;
    end

    // release away from the rising edge
    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge audgen_mclk);
        @(negedge audgen_mclk);
        reset_n = 1'b1;
    end

endmodule

// ==== tb_test_signal_top.sv ====
// outputs are sampled on falling mclk edges and one run spans about three video frames
`timescale 1ns/10ps

module tb_test_signal_top;

    logic                           audgen_mclk;
    logic                           reset_n;
    test_signal_pkg::audio_sample_t sample;
    test_signal_pkg::video_out_t    video;
    test_signal_pkg::i2s_out_t      i2s;
    logic                           sample_taken;

    logic [31:0] lfsr;
    int          value_errors;
    int          event_errors;
    int          f;

    tb_clock_gen tb_clock_gen_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n)
    );

    test_signal_top test_signal_top_i (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .sample       (sample),
        .video        (video),
        .i2s          (i2s),
        .sample_taken (sample_taken)
    );

    ////////////////////////////////////////////////////////////
    // random source and error reporting
    ////////////////////////////////////////////////////////////

    // galois form with maximal 32-bit taps
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one step per bit taken
    function automatic logic [15:0] random_word();
        logic [15:0] r;
        int          k;
        r = '0;
        for (k = 0; k < 16; k++) begin
            r    = {r[14:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        value_errors++;
    endtask

    task automatic flag_failure(input string what);
        $display("failure at %0t: %s", $time, what);
        event_errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // bounded waits, all on falling edges
    ////////////////////////////////////////////////////////////

    task automatic wait_vs(input int limit);
        int n;
        n = 0;
        @(negedge audgen_mclk);
        while (!video.vs && n < limit) begin
            @(negedge audgen_mclk);
            n++;
        end
        if (!video.vs) flag_failure("no vs pulse within the timeout");
    endtask

    task automatic wait_sample_taken(input int limit);
        int n;
        n = 0;
        @(negedge audgen_mclk);
        while (!sample_taken && n < limit) begin
            @(negedge audgen_mclk);
            n++;
        end
        if (!sample_taken) flag_failure("no sample_taken pulse within the timeout");
    endtask

    // returns on the first falling edge that sees sclk high after low
    task automatic wait_sclk_rise(input int limit);
        logic prev;
        int   n;
        prev = i2s.sclk;
        n    = 0;
        @(negedge audgen_mclk);
        while (!(i2s.sclk && !prev) && n < limit) begin
            prev = i2s.sclk;
            @(negedge audgen_mclk);
            n++;
        end
        if (!(i2s.sclk && !prev)) flag_failure("sclk did not rise within the timeout");
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic check_idle();
        if (video.vs !== 1'b0) flag_mismatch("vs", 32'(video.vs), 32'h0);
        if (video.hs !== 1'b0) flag_mismatch("hs", 32'(video.hs), 32'h0);
        if (video.de !== 1'b0) flag_mismatch("de", 32'(video.de), 32'h0);
        if (video.rgb !== 24'h0) flag_mismatch("rgb", 32'(video.rgb), 32'h0);
        if (i2s.sclk !== 1'b0) flag_mismatch("sclk", 32'(i2s.sclk), 32'h0);
        if (i2s.lrck !== 1'b0) flag_mismatch("lrck", 32'(i2s.lrck), 32'h0);
        if (i2s.dac !== 1'b0) flag_mismatch("dac", 32'(i2s.dac), 32'h0);
        if (sample_taken !== 1'b0) flag_mismatch("sample_taken", 32'(sample_taken), 32'h0);
    endtask

    // every cycle in reset plus the half cycle after release before any rising edge
    task automatic reset_test();
        logic released;
        int   n;
        released = 1'b0;
        n        = 0;
        while (!released && n < 40) begin
            @(negedge audgen_mclk);
            #1;
            released = reset_n;
            check_idle();
            n++;
        end
        if (!released) flag_failure("reset was never released");
    endtask

    // 400 x 512 clocks per frame and one hs per line
    task automatic raster_frame_test();
        int cyc;
        int hs_count;
        int last_hs;
        wait_vs(250000);
        cyc      = 0;
        hs_count = 0;
        last_hs  = -1;
        do begin
            @(negedge audgen_mclk);
            cyc++;
            if (video.hs) begin
                if (last_hs >= 0 && cyc - last_hs != 400) begin
                    flag_mismatch("hs spacing", 32'(cyc - last_hs), 32'd400);
                end
                last_hs = cyc;
                hs_count++;
            end
        end while (!video.vs && cyc < 205000);
        if (cyc != 204800) flag_mismatch("vs period", 32'(cyc), 32'd204800);
        if (hs_count != 512) flag_mismatch("hs per frame", 32'(hs_count), 32'd512);
    endtask

    // 240 runs of 320 active pixels with orange inside and black outside
    task automatic active_window_test();
        int   cyc;
        int   de_total;
        int   runs;
        int   run_len;
        logic prev_de;
        wait_vs(250000);
        de_total = 0;
        runs     = 0;
        run_len  = 0;
        prev_de  = video.de;
        for (cyc = 0; cyc < 204800; cyc++) begin
            @(negedge audgen_mclk);
            if (video.de) begin
                if (video.rgb != 24'hFF5F00) flag_mismatch("rgb", 32'(video.rgb), 32'hFF5F00);
                de_total++;
                run_len++;
            end else begin
                if (video.rgb != 24'h0) flag_mismatch("rgb", 32'(video.rgb), 32'h0);
                // end of a run
                if (prev_de) begin
                    if (run_len != 320) flag_mismatch("de run", 32'(run_len), 32'd320);
                    runs++;
                end
                run_len = 0;
            end
            prev_de = video.de;
        end
        if (de_total != 76800) flag_mismatch("de cycles", 32'(de_total), 32'd76800);
        if (runs != 240) flag_mismatch("de runs", 32'(runs), 32'd240);
    endtask

    task automatic i2s_clock_test();
        int   cyc;
        int   last_sclk;
        int   last_lrck;
        int   last_take;
        int   edges;
        logic prev_sclk;
        logic prev_lrck;
        @(negedge audgen_mclk);
        prev_sclk = i2s.sclk;
        prev_lrck = i2s.lrck;
        last_sclk = -1;
        last_lrck = -1;
        last_take = -1;
        edges     = 0;
        for (cyc = 1; cyc <= 1024; cyc++) begin
            @(negedge audgen_mclk);
            if (i2s.sclk && !prev_sclk) begin
                if (last_sclk >= 0 && cyc - last_sclk != 4) begin
                    flag_mismatch("sclk period", 32'(cyc - last_sclk), 32'd4);
                end
                last_sclk = cyc;
            end
            // 32 sclk periods per channel
            if (i2s.lrck != prev_lrck) begin
                if (last_lrck >= 0 && cyc - last_lrck != 128) begin
                    flag_mismatch("lrck half period", 32'(cyc - last_lrck), 32'd128);
                end
                last_lrck = cyc;
                edges++;
            end
            if (sample_taken) begin
                if (last_take >= 0 && cyc - last_take != 256) begin
                    flag_mismatch("sample_taken period", 32'(cyc - last_take), 32'd256);
                end
                last_take = cyc;
            end
            prev_sclk = i2s.sclk;
            prev_lrck = i2s.lrck;
        end
        if (last_sclk < 0) flag_failure("sclk never rose");
        if (edges < 6) flag_failure("lrck toggled too rarely to measure");
        if (last_take < 0) flag_failure("sample_taken never pulsed");
    endtask

    // rebuilds one frame from dac at rising sclk and drives the next pair at change_slot
    // or at once when change_slot is negative
    task automatic frame_check(input int change_slot);
        test_signal_pkg::audio_sample_t expect_s;
        logic [63:0]                    bits;
        logic                           exp_lrck;
        int                             i;
        wait_sample_taken(300);
        expect_s = sample;
        bits     = '0;
        if (change_slot < 0) begin
            sample.left  = random_word();
            sample.right = random_word();
        end
        for (i = 0; i < 64; i++) begin
            wait_sclk_rise(8);
            bits     = {bits[62:0], i2s.dac};
            exp_lrck = (i >= 32);
            if (i2s.lrck != exp_lrck) flag_mismatch("lrck", 32'(i2s.lrck), 32'(exp_lrck));
            if (i == change_slot) begin
                sample.left  = random_word();
                sample.right = random_word();
            end
        end
        if (bits[63:48] != expect_s.left) begin
            flag_mismatch("dac left", 32'(bits[63:48]), 32'(expect_s.left));
        end
        if (bits[47:32] != 16'h0) flag_mismatch("dac left pad", 32'(bits[47:32]), 32'h0);
        if (bits[31:16] != expect_s.right) begin
            flag_mismatch("dac right", 32'(bits[31:16]), 32'(expect_s.right));
        end
        if (bits[15:0] != 16'h0) flag_mismatch("dac right pad", 32'(bits[15:0]), 32'h0);
    endtask

    ////////////////////////////////////////////////////////////
    // sequence and final report
    ////////////////////////////////////////////////////////////

    initial begin
        sample       = '0;
        lfsr         = 32'h8bd2;
        value_errors = 0;
        event_errors = 0;
        reset_test();
        raster_frame_test();
        active_window_test();
        i2s_clock_test();
        // a random pair per frame
        for (f = 0; f < 4; f++) begin
            frame_check(-1);
        end
        // change in right data and then the frame that picks it up
        frame_check(40);
        frame_check(-1);
        $display("errors: %0d value, %0d other", value_errors, event_errors);
        if (value_errors == 0 && event_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
test_signal_pkg.sv
raster_counter.sv
video_pattern.sv
i2s_sequencer.sv
i2s_serializer.sv
test_signal_top.sv
tb_clock_gen.sv
tb_test_signal_top.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_test_signal_top

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

$(SIM): verilog.f $(shell cat verilog.f)
	verilator --binary --timing -f verilog.f --top-module tb_test_signal_top \
		-o Vtb_test_signal_top

clean:
	rm -rf obj_dir
